// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := fetch_f2_tb
FILELIST  := fetch_f2_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := sim failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== fetch_f2_top.f ====
+incdir+include
hw/fetch_pkg.sv
hw/fetch_ifs.sv
hw/btb.sv
hw/pc_gen.sv
hw/ibuff_alloc.sv
hw/ibuff_slot.sv
hw/ibuff_drain.sv
hw/fetch_f2_top.sv
test/fetch_f2_checker.sv
test/fetch_f2_tb.sv

// ==== hw/btb.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module btb import fetch_pkg::*; #(
    parameter int ENTRIES = `FETCH_BTB_ENTRIES
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  upd_valid,   // Branch resolved
    input  addr_t upd_pc,
    input  addr_t upd_target,
    input  logic  upd_taken,
    pred_if.btb   pred
);
    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TAG_W = 32 - 6 - IDX_W;  // Address bits above index

    logic [ENTRIES-1:0] valid_q;           // Only state with reset
    logic [TAG_W-1:0]   tag_q [ENTRIES];
    logic [ENTRIES-1:0] taken_q;
    addr_t              target_q [ENTRIES];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] up_idx;
    logic [TAG_W-1:0] up_tag;
    logic             lk_match;

    // Index by line address so any PC in the line hits
    assign lk_idx = pred.lookup_pc[6 +: IDX_W];
    assign lk_tag = pred.lookup_pc[31 -: TAG_W];
    assign up_idx = upd_pc[6 +: IDX_W];
    assign up_tag = upd_pc[31 -: TAG_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_valid) begin
            valid_q[up_idx] <= 1'b1;  // Not taken update keeps entry alive
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (upd_valid) begin
            tag_q[up_idx]    <= up_tag;
            taken_q[up_idx]  <= upd_taken;  // Resolved direction, no counters
            target_q[up_idx] <= upd_target;
        end
    end

    assign lk_match = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

    assign pred.hit    = lk_match;
    assign pred.taken  = lk_match && taken_q[lk_idx];  // Never taken on a miss
    assign pred.target = target_q[lk_idx];

endmodule

// ==== hw/fetch_f2_top.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_f2_top import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Redirects
    input  logic      rob_valid,
    input  addr_t     rob_target,
    input  logic      d1_valid,
    input  addr_t     d1_target,
    input  logic      ras_valid,
    input  addr_t     ras_target,
    // Branch resolution
    input  logic      upd_valid,
    input  addr_t     upd_pc,
    input  addr_t     upd_target,
    input  logic      upd_taken,
    // Instruction cache
    output logic      req_valid,
    output addr_t     req_addr,
    input  logic      fill_valid,
    input  line_t     fill_line,
    // Decoder
    input  logic      dec_credit,
    output logic      pkt_valid,
    output pkt_data_t pkt_data,
    output addr_t     pkt_pc,
    output pkt_len_t  pkt_len
);
    logic flush;
    logic can_issue;
    logic rel;

    pred_if pred_bus ();
    slot_if slot_bus [`FETCH_NUM_SLOTS] ();

    btb u_btb (
        .clk        (clk),
        .rst        (rst),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_target (upd_target),
        .upd_taken  (upd_taken),
        .pred       (pred_bus)
    );

    pc_gen u_pc_gen (
        .clk        (clk),
        .rst        (rst),
        .rob_valid  (rob_valid),
        .rob_target (rob_target),
        .d1_valid   (d1_valid),
        .d1_target  (d1_target),
        .ras_valid  (ras_valid),
        .ras_target (ras_target),
        .can_issue  (can_issue),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .flush      (flush),
        .pred       (pred_bus)
    );

    ibuff_alloc #(.NUM_SLOTS(`FETCH_NUM_SLOTS)) u_alloc (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .flush      (flush),
        .fill_valid (fill_valid),
        .fill_line  (fill_line),
        .rel        (rel),
        .can_issue  (can_issue),
        .slots      (slot_bus)
    );

    // Ring of identical line slots
    for (genvar i = 0; i < `FETCH_NUM_SLOTS; i++) begin : g_slot
        ibuff_slot u_slot (
            .clk   (clk),
            .rst   (rst),
            .flush (flush),
            .port  (slot_bus[i])
        );
    end

    ibuff_drain #(
        .NUM_SLOTS   (`FETCH_NUM_SLOTS),
        .DEC_CREDITS (`FETCH_DEC_CREDITS)
    ) u_drain (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .dec_credit (dec_credit),
        .slots      (slot_bus),
        .rel        (rel),
        .pkt_valid  (pkt_valid),
        .pkt_data   (pkt_data),
        .pkt_pc     (pkt_pc),
        .pkt_len    (pkt_len)
    );

endmodule

// ==== hw/fetch_ifs.sv ====
`timescale 1ns/1ps

// BTB lookup port, answered in the same cycle
interface pred_if import fetch_pkg::*; ();
    addr_t lookup_pc;  // Current fetch PC
    logic  hit;
    logic  taken;
    addr_t target;

    modport btb (
        input  lookup_pc,
        output hit,
        output taken,
        output target
    );

    modport pc (
        output lookup_pc,
        input  hit,
        input  taken,
        input  target
    );
endinterface

// One instruction buffer slot
interface slot_if import fetch_pkg::*; ();
    logic    wr_en;       // Fill write from allocator
    line_t   wr_line;
    offset_t wr_offset;   // First fetch byte of the line
    addr_t   wr_pc;
    logic    rd_release;  // Drain is done with this slot
    logic    valid;
    line_t   line;
    offset_t offset;
    addr_t   pc;

    modport alloc (output wr_en, output wr_line, output wr_offset, output wr_pc);

    modport drain (output rd_release, input valid, input line, input offset, input pc);

    modport slot (
        input  wr_en,
        input  wr_line,
        input  wr_offset,
        input  wr_pc,
        input  rd_release,
        output valid,
        output line,
        output offset,
        output pc
    );
endinterface

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0]  addr_t;      // Fetch address
    typedef logic [511:0] line_t;      // 64 byte cache line
    typedef logic [127:0] pkt_data_t;  // 16 byte decoder packet
    typedef logic [5:0]   offset_t;    // Byte within a line
    typedef logic [4:0]   pkt_len_t;   // Valid packet bytes 1 to 16

    // Why the PC last left sequential order
    typedef enum logic [2:0] {
        REDIR_NONE = 3'd0,
        REDIR_ROB  = 3'd1,
        REDIR_D1   = 3'd2,
        REDIR_RAS  = 3'd3,
        REDIR_BTB  = 3'd4
    } redirect_src_e;

    // Drain FSM
    typedef enum logic {
        DRAIN_IDLE   = 1'b0,  // Waiting for head slot
        DRAIN_STREAM = 1'b1   // Sending packets from head slot
    } drain_state_e;

endpackage

// ==== hw/ibuff_alloc.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module ibuff_alloc import fetch_pkg::*; #(
    parameter int NUM_SLOTS = `FETCH_NUM_SLOTS
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  req_valid,  // Request accepted by cache this cycle
    input  addr_t req_addr,
    input  logic  flush,
    input  logic  fill_valid,  // Fills return in request order
    input  line_t fill_line,
    input  logic  rel,         // Drain freed the head slot
    output logic  can_issue,
    slot_if.alloc slots [NUM_SLOTS]
);
    localparam int PTR_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int CNT_W = $clog2(NUM_SLOTS + 1);

    addr_t            addr_q [NUM_SLOTS];  // Addresses of requests in flight
    logic [PTR_W-1:0] push_ptr_q;
    logic [PTR_W-1:0] pop_ptr_q;
    logic [PTR_W-1:0] tail_q;              // Next slot to fill
    logic [CNT_W-1:0] inflight_q;          // Includes fills marked for drop
    logic [CNT_W-1:0] occ_q;               // Slots holding a line
    logic [CNT_W-1:0] drop_q;              // Stale fills still to come
    logic             fill_wr;
    addr_t            fill_addr;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(NUM_SLOTS - 1)) ? '0 : p + 1'b1;
    endfunction

    // Every request reserves a slot until its fill lands or drops
    assign can_issue = ({1'b0, inflight_q} + {1'b0, occ_q}) < (CNT_W + 1)'(NUM_SLOTS);

    assign fill_addr = addr_q[pop_ptr_q];
    assign fill_wr   = fill_valid && (drop_q == '0) && !flush;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_wr
        assign slots[i].wr_en     = fill_wr && (tail_q == PTR_W'(i));
        assign slots[i].wr_line   = fill_line;
        assign slots[i].wr_offset = fill_addr[5:0];
        assign slots[i].wr_pc     = fill_addr;
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            addr_q[push_ptr_q] <= req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            push_ptr_q <= '0;
            pop_ptr_q  <= '0;
            tail_q     <= '0;
            inflight_q <= '0;
            occ_q      <= '0;
            drop_q     <= '0;
        end else begin
            // Address FIFO runs through flushes, stale fills still pop it
            if (req_valid) push_ptr_q <= ptr_inc(push_ptr_q);
            if (fill_valid) pop_ptr_q <= ptr_inc(pop_ptr_q);
            inflight_q <= inflight_q + CNT_W'(req_valid) - CNT_W'(fill_valid);
            if (flush) begin
                drop_q <= inflight_q - CNT_W'(fill_valid);  // Fill this cycle is lost too
                tail_q <= '0;
                occ_q  <= '0;
            end else begin
                if (fill_valid && (drop_q != '0)) drop_q <= drop_q - 1'b1;
                if (fill_wr) tail_q <= ptr_inc(tail_q);
                occ_q <= occ_q + CNT_W'(fill_wr) - CNT_W'(rel);
            end
        end
    end

endmodule

// ==== hw/ibuff_drain.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module ibuff_drain import fetch_pkg::*; #(
    parameter int NUM_SLOTS   = `FETCH_NUM_SLOTS,
    parameter int DEC_CREDITS = `FETCH_DEC_CREDITS
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      dec_credit,  // Decoder consumed one packet
    slot_if.drain     slots [NUM_SLOTS],
    output logic      rel,         // Head slot freed
    output logic      pkt_valid,
    output pkt_data_t pkt_data,
    output addr_t     pkt_pc,
    output pkt_len_t  pkt_len
);
    localparam int PTR_W  = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int CRED_W = $clog2(DEC_CREDITS + 1);

    drain_state_e      state_q;
    logic [PTR_W-1:0]  head_q;
    logic [PTR_W-1:0]  head_nxt;
    offset_t           cursor_q;   // Byte of the next packet
    logic [CRED_W-1:0] credit_q;

    logic [NUM_SLOTS-1:0] valid_a;
    line_t                line_a   [NUM_SLOTS];
    offset_t              offset_a [NUM_SLOTS];
    addr_t                pc_a     [NUM_SLOTS];

    logic [6:0]    remain;    // Bytes left in the head line
    logic          last;
    logic          send;
    logic [1023:0] rot;
    addr_t         head_pc;

    // Flatten slots so the head can be picked by a variable index
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_rd
        assign valid_a[i]          = slots[i].valid;
        assign line_a[i]           = slots[i].line;
        assign offset_a[i]         = slots[i].offset;
        assign pc_a[i]             = slots[i].pc;
        assign slots[i].rd_release = rel && (head_q == PTR_W'(i));
    end

    assign head_nxt = (head_q == PTR_W'(NUM_SLOTS - 1)) ? '0 : head_q + 1'b1;

    assign remain = 7'd64 - {1'b0, cursor_q};
    assign last   = remain <= 7'd16;
    assign send   = (state_q == DRAIN_STREAM) && (credit_q != '0) && !flush;
    assign rel    = send && last;

    // Rotate right by cursor bytes, low 16 bytes form the packet
    assign rot     = {line_a[head_q], line_a[head_q]} >> {cursor_q, 3'b000};
    assign head_pc = pc_a[head_q];

    assign pkt_valid = send;
    assign pkt_data  = rot[127:0];
    assign pkt_pc    = {head_pc[31:6], cursor_q};  // Line base plus cursor
    assign pkt_len   = last ? remain[4:0] : 5'd16;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= DRAIN_IDLE;
            head_q   <= '0;
            cursor_q <= '0;
            credit_q <= CRED_W'(DEC_CREDITS);
        end else begin
            // Credits belong to the decoder and survive a flush
            credit_q <= credit_q + CRED_W'(dec_credit) - CRED_W'(send);
            if (flush) begin
                state_q  <= DRAIN_IDLE;
                head_q   <= '0;
                cursor_q <= '0;
            end else begin
                case (state_q)
                    DRAIN_IDLE: begin
                        if (valid_a[head_q]) begin
                            cursor_q <= offset_a[head_q];
                            state_q  <= DRAIN_STREAM;
                        end
                    end
                    DRAIN_STREAM: begin
                        if (send && last) begin
                            head_q <= head_nxt;
                            // Go straight on if the next line is already here
                            if (valid_a[head_nxt]) cursor_q <= offset_a[head_nxt];
                            else state_q <= DRAIN_IDLE;
                        end else if (send) begin
                            cursor_q <= cursor_q + 6'd16;
                        end
                    end
                    default: state_q <= DRAIN_IDLE;
                endcase
            end
        end
    end

endmodule

// ==== hw/ibuff_slot.sv ====
`timescale 1ns/1ps

module ibuff_slot import fetch_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic flush,  // Redirect empties every slot
    slot_if.slot port
);
    logic    valid_q;
    line_t   line_q;
    offset_t offset_q;  // Fetch byte of the first packet
    addr_t   pc_q;

    // Write and release never hit the same slot in one cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
        end else if (port.wr_en) begin
            valid_q <= 1'b1;
        end else if (port.rd_release) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            line_q   <= port.wr_line;
            offset_q <= port.wr_offset;
            pc_q     <= port.wr_pc;
        end
    end

    assign port.valid  = valid_q;
    assign port.line   = line_q;
    assign port.offset = offset_q;
    assign port.pc     = pc_q;

endmodule

// ==== hw/pc_gen.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module pc_gen import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rob_valid,   // Highest priority
    input  addr_t rob_target,
    input  logic  d1_valid,
    input  addr_t d1_target,
    input  logic  ras_valid,   // Lowest priority
    input  addr_t ras_target,
    input  logic  can_issue,   // Allocator has a free slot
    output logic  req_valid,
    output addr_t req_addr,
    output logic  flush,
    pred_if.pc    pred
);
    addr_t         pc_q;
    addr_t         pc_n;
    addr_t         seq_pc;
    logic          run_q;        // Low for one cycle after reset
    redirect_src_e redir_src_q;  // Cause of last PC change
    redirect_src_e redir_src_n;

    // Any redirect flushes the buffer and fills in flight
    assign flush = rob_valid | d1_valid | ras_valid;

    // No request in a flush cycle, the PC is about to move
    assign req_valid = run_q && can_issue && !flush;
    assign req_addr  = pc_q;

    assign pred.lookup_pc = pc_q;

    // Next line, fetch offset dropped
    assign seq_pc = {pc_q[31:6], 6'd0} + 32'd64;

    always_comb begin
        pc_n        = pc_q;
        redir_src_n = redir_src_q;
        if (rob_valid) begin
            pc_n        = rob_target;
            redir_src_n = REDIR_ROB;
        end else if (d1_valid) begin
            pc_n        = d1_target;
            redir_src_n = REDIR_D1;
        end else if (ras_valid) begin
            pc_n        = ras_target;
            redir_src_n = REDIR_RAS;
        end else if (req_valid) begin
            // Step only when the line request went out
            if (pred.hit && pred.taken) begin
                pc_n        = pred.target;
                redir_src_n = REDIR_BTB;
            end else begin
                pc_n        = seq_pc;
                redir_src_n = REDIR_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q        <= `FETCH_RESET_PC;
            run_q       <= 1'b0;
            redir_src_q <= REDIR_NONE;
        end else begin
            pc_q        <= pc_n;
            run_q       <= 1'b1;
            redir_src_q <= redir_src_n;
        end
    end

endmodule

// ==== include/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Instruction buffer depth in lines
`define FETCH_NUM_SLOTS 4

// Packets the decoder can hold
`define FETCH_DEC_CREDITS 4

// Direct mapped BTB size, power of two
`define FETCH_BTB_ENTRIES 16

// Where fetch starts after reset
`define FETCH_RESET_PC 32'h0000_1000

`endif

// ==== test/fetch_f2_checker.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_f2_checker import fetch_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic          req_valid,
    input logic          fill_valid,
    input logic          flush,
    input logic          rel,
    input logic          dec_credit,
    input logic          pkt_valid,
    input logic          rob_valid,
    input logic          d1_valid,
    input redirect_src_e redir_src   // Cause register inside pc_gen
);
    int inflight;  // Requests not yet filled, stale ones too
    int drop;      // Fills still to be thrown away
    int held;      // Lines sitting in slots
    int credits;   // Packets the decoder can still take

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= 0;
            drop     <= 0;
            held     <= 0;
            credits  <= `FETCH_DEC_CREDITS;
        end else begin
            inflight <= inflight + int'(req_valid) - int'(fill_valid);
            credits  <= credits + int'(dec_credit) - int'(pkt_valid);
            if (flush) begin
                drop <= inflight - int'(fill_valid);  // Fill in the flush cycle is lost
                held <= 0;
            end else if (fill_valid && drop > 0) begin
                drop <= drop - 1;
                held <= held - int'(rel);
            end else begin
                held <= held + int'(fill_valid) - int'(rel);
            end
        end
    end

    // Quiet outputs through reset and the cycle after
    a_rst_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !req_valid && !pkt_valid)
        else $error("request or packet while in reset");
    a_rst_exit: assert property (@(posedge clk) $fell(rst) |-> !req_valid && !pkt_valid)
        else $error("request or packet in first cycle after reset");

    a_credit: assert property (@(posedge clk) disable iff (rst) pkt_valid |-> credits > 0)
        else $error("packet sent with no decoder credit");

    a_slots: assert property (@(posedge clk) disable iff (rst)
        inflight + held <= `FETCH_NUM_SLOTS)
        else $error("requests in flight plus lines exceed slot count");

    // Redirect priority seen in the recorded cause
    a_src_rob: assert property (@(posedge clk) disable iff (rst)
        rob_valid |=> redir_src == REDIR_ROB)
        else $error("ROB redirect not recorded as the cause");
    a_src_d1: assert property (@(posedge clk) disable iff (rst)
        d1_valid && !rob_valid |=> redir_src == REDIR_D1)
        else $error("D1 redirect not recorded as the cause");
    a_src_ras: assert property (@(posedge clk) disable iff (rst)
        flush && !rob_valid && !d1_valid |=> redir_src == REDIR_RAS)
        else $error("RAS redirect not recorded as the cause");

    // Drain restarts idle after a redirect
    a_flush_drain: assert property (@(posedge clk) disable iff (rst) flush |=> !pkt_valid)
        else $error("packet right after a flush");

endmodule

// ==== test/fetch_f2_tb.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_f2_tb import fetch_pkg::*; ();
    localparam int NUM_SLOTS       = `FETCH_NUM_SLOTS;
    localparam int DEC_CREDITS     = `FETCH_DEC_CREDITS;
    localparam int BTB_N           = `FETCH_BTB_ENTRIES;
    localparam int RUN_CYCLES      = 4000;
    localparam int FIRST_REQ_LIMIT = 20;   // Cycles allowed until first request
    localparam int STALL_LIMIT     = 100;  // Cycles with neither request nor packet
    localparam int MAX_MISMATCH    = 20;

    logic      clk;
    logic      rst;
    logic      rob_valid;
    addr_t     rob_target;
    logic      d1_valid;
    addr_t     d1_target;
    logic      ras_valid;
    addr_t     ras_target;
    logic      upd_valid;
    addr_t     upd_pc;
    addr_t     upd_target;
    logic      upd_taken;
    logic      req_valid;
    addr_t     req_addr;
    logic      fill_valid;
    line_t     fill_line;
    logic      dec_credit;
    logic      pkt_valid;
    pkt_data_t pkt_data;
    addr_t     pkt_pc;
    pkt_len_t  pkt_len;

    // Reference model state
    bit          m_valid  [BTB_N];
    logic [25:0] m_line   [BTB_N];  // Line number stands in for index plus tag
    bit          m_taken  [BTB_N];
    addr_t       m_target [BTB_N];
    addr_t       exp_pc;
    int          model_credits;
    int          model_lines;       // Lines buffered in slots

    addr_t     cache_addr_q [$];    // Cache requests in order
    int        cache_due_q [$];
    bit        cache_stale_q [$];   // Requested before a redirect
    pkt_data_t exp_data_q [$];
    addr_t     exp_pc_q [$];
    pkt_len_t  exp_len_q [$];
    bit        exp_last_q [$];

    int cyc;
    int idle_cycles;
    int credit_pct;
    int checks;
    int mismatches;
    int other_errs;
    int reqs;
    int pkts;
    int redirects;
    addr_t first_req;
    bit stop;

    fetch_f2_top dut (.*);

    bind fetch_f2_top fetch_f2_checker chk (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .fill_valid (fill_valid),
        .flush      (flush),
        .rel        (rel),
        .dec_credit (dec_credit),
        .pkt_valid  (pkt_valid),
        .rob_valid  (rob_valid),
        .d1_valid   (d1_valid),
        .redir_src  (u_pc_gen.redir_src_q)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] byte_hash(input addr_t a);
        logic [31:0] h;
        h = a ^ (a >> 9);
        h = h * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        return h[7:0];
    endfunction

    function automatic line_t make_line(input addr_t a);
        line_t ln;
        addr_t base;
        base = {a[31:6], 6'd0};
        for (int i = 0; i < 64; i++) ln[i*8 +: 8] = byte_hash(base + 32'(i));
        return ln;
    endfunction

    // Random address in a 4 KB window so BTB entries get reused
    function automatic addr_t rand_target();
        return {20'h00001, 12'($urandom)};
    endfunction

    // Sequential line step unless the model BTB says taken
    function automatic addr_t next_fetch(input addr_t pc);
        int idx;
        idx = int'(pc[31:6] % BTB_N);
        if (m_valid[idx] && m_line[idx] == pc[31:6] && m_taken[idx]) return m_target[idx];
        return {pc[31:6], 6'd0} + 32'd64;
    endfunction

    // Expected packets of one line, 16 bytes from the fetch byte on
    task automatic queue_packets(input addr_t a);
        addr_t     base;
        int        cur;
        int        len;
        pkt_data_t d;
        base = {a[31:6], 6'd0};
        cur  = int'(a[5:0]);
        while (cur < 64) begin
            len = (64 - cur < 16) ? 64 - cur : 16;
            for (int k = 0; k < 16; k++) d[k*8 +: 8] = byte_hash(base + 32'((cur + k) % 64));
            exp_data_q.push_back(d);
            exp_pc_q.push_back(base + 32'(cur));
            exp_len_q.push_back(pkt_len_t'(len));
            exp_last_q.push_back(cur + 16 >= 64);
            cur += 16;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pkt(input string name, input pkt_data_t got, input pkt_data_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input pkt_len_t got, input pkt_len_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        other_errs++;
        $display("error t=%0t %s", $time, what);
    endtask

    // Last look is what the first edge with rst low samples
    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) begin
            @(negedge clk);
            if (req_valid || pkt_valid) report_error("request or packet in reset or the cycle after");
        end
        rst = 1'b0;  // Still at the fifth falling edge
    endtask

    // One clock: drive at the falling edge, then check what the next edge takes
    task automatic run_cycle(input bit allow_redirect);
        logic [2:0] pick;
        bit         redir;
        bit         fill_go;
        bit         fill_stale;
        addr_t      fill_addr;
        int         held_before;
        int         idx;

        @(negedge clk);
        pick       = 3'(1 + ($urandom % 7));  // Sources firing together, never none
        redir      = allow_redirect && (($urandom % 32) == 0);
        rob_valid  = redir && pick[0];
        d1_valid   = redir && pick[1];
        ras_valid  = redir && pick[2];
        rob_target = rand_target();
        d1_target  = rand_target();
        ras_target = rand_target();
        upd_valid  = ($urandom % 8) == 0;
        upd_pc     = rand_target();
        upd_target = rand_target();
        upd_taken  = 1'($urandom);
        fill_go    = cache_addr_q.size() > 0 && cyc >= cache_due_q[0];
        fill_valid = fill_go;
        fill_line  = fill_go ? make_line(cache_addr_q[0]) : '0;
        dec_credit = (model_credits < DEC_CREDITS) && (($urandom % 100) < credit_pct);
        #1;
        held_before = cache_addr_q.size() + model_lines;

        // Decoder side
        if (pkt_valid) begin
            idle_cycles = 0;
            pkts++;
            if (redir) report_error("packet sent during a redirect");
            else if (model_credits == 0) report_error("packet sent with no decoder credit");
            else if (exp_data_q.size() == 0) report_error("packet with no line expected");
            else begin
                check_addr("pkt_pc", pkt_pc, exp_pc_q[0]);
                check_pkt("pkt_data", pkt_data, exp_data_q[0]);
                check_len("pkt_len", pkt_len, exp_len_q[0]);
                if (exp_last_q[0]) model_lines--;  // Slot freed
                void'(exp_data_q.pop_front());
                void'(exp_pc_q.pop_front());
                void'(exp_len_q.pop_front());
                void'(exp_last_q.pop_front());
            end
            if (model_credits > 0) model_credits--;
        end
        if (dec_credit) model_credits++;

        // Cache fill, stale or flushed fills never reach a slot
        if (fill_go) begin
            fill_addr  = cache_addr_q.pop_front();
            fill_stale = cache_stale_q.pop_front();
            void'(cache_due_q.pop_front());
            if (!fill_stale && !redir) begin
                queue_packets(fill_addr);
                model_lines++;
            end
        end

        // Cache request
        if (req_valid) begin
            idle_cycles = 0;
            if (redir) report_error("request raised during a redirect");
            else begin
                if (held_before >= NUM_SLOTS) report_error("request with every slot taken");
                if (reqs == 0) first_req = req_addr;
                check_addr("req_addr", req_addr, exp_pc);
                cache_addr_q.push_back(req_addr);
                cache_due_q.push_back(cyc + 1 + int'($urandom % 6));
                cache_stale_q.push_back(1'b0);
                exp_pc = next_fetch(exp_pc);  // Lookup sees table before update
                reqs++;
            end
        end

        // ROB over D1 over RAS
        if (redir) begin
            redirects++;
            exp_pc = rob_valid ? rob_target : (d1_valid ? d1_target : ras_target);
            foreach (cache_stale_q[i]) cache_stale_q[i] = 1'b1;
            exp_data_q.delete();
            exp_pc_q.delete();
            exp_len_q.delete();
            exp_last_q.delete();
            model_lines = 0;
        end

        if (upd_valid) begin
            idx           = int'(upd_pc[31:6] % BTB_N);
            m_valid[idx]  = 1'b1;
            m_line[idx]   = upd_pc[31:6];
            m_taken[idx]  = upd_taken;  // Not taken keeps the entry alive
            m_target[idx] = upd_target;
        end

        if (cache_addr_q.size() + model_lines > NUM_SLOTS) begin
            report_error("requests in flight plus buffered lines exceed the slot count");
        end

        idle_cycles++;
        if (idle_cycles > STALL_LIMIT) begin
            report_error("no request or packet for too many cycles");
            stop = 1'b1;
        end
        cyc++;
    endtask

    initial begin
        int n;
        void'($urandom(32'h120d));
        rst        = 1'b1;
        rob_valid  = 1'b0;
        rob_target = '0;
        d1_valid   = 1'b0;
        d1_target  = '0;
        ras_valid  = 1'b0;
        ras_target = '0;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_target = '0;
        upd_taken  = 1'b0;
        fill_valid = 1'b0;
        fill_line  = '0;
        dec_credit = 1'b0;
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        exp_pc        = `FETCH_RESET_PC;
        model_credits = DEC_CREDITS;
        model_lines   = 0;
        credit_pct    = 80;
        apply_reset();

        // First request, no redirects yet
        n = 0;
        while (!stop && reqs == 0 && n < FIRST_REQ_LIMIT) begin
            run_cycle(1'b0);
            n++;
        end
        if (reqs == 0) report_error("no request after reset");
        else check_addr("first req_addr", first_req, `FETCH_RESET_PC);

        // Random traffic, decoder slows down then recovers
        n = 0;
        while (!stop && n < RUN_CYCLES) begin
            if (n < RUN_CYCLES / 3) credit_pct = 80;
            else if (n < 2 * RUN_CYCLES / 3) credit_pct = 15;
            else credit_pct = 50;
            run_cycle(1'b1);
            n++;
            if (mismatches > MAX_MISMATCH) begin
                report_error("too many mismatches, run stopped");
                stop = 1'b1;
            end
        end
        if (pkts == 0 || redirects == 0) report_error("traffic never reached packets or redirects");

        $display("errors: %0d mismatches, %0d other, %0d checks, %0d reqs, %0d pkts, %0d redirects",
                 mismatches, other_errs, checks, reqs, pkts, redirects);
        if (mismatches == 0 && other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
